/* rom_image.hex */
// one 32-bit ROM word per line, word index 0 upward
B0070000
B0070001
B0070002
B0070003
B0070004
B0070005
B0070006
B0070007
B0070008
B0070009
B007000A
B007000B
B007000C
B007000D
B007000E
B007000F

/* sources.f */
soc_pkg.sv
rst_conditioner.sv
heartbeat_blinker.sv
boot_rom.sv
dmem_slave_mux.sv
soc_fabric_top.sv
soc_asserts.sv
tb_soc.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_soc -f sources.f -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_soc.sv */
/*
 * directed testbench for soc_fabric_top with a small UART responder.
 * inputs change 2 ns after cpu_clk rises; bus outputs are sampled mid-cycle.
 * expects rom_image.hex with word i = 32'hB0070000 + i for i in 0..15.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_soc;
    import soc_pkg::*;

    localparam logic [31:0] rom_base  = 32'hFFEE0000;
    localparam logic [31:0] uart_base = 32'hFFDF0000;
    // tests run a few hundred cycles
    localparam int timeout_cycles = 2000;

    logic cpu_clk, hard_rst_n, ext_rst_n;
    bus_addr_t imem_haddr, dmem_haddr;
    logic [1:0] imem_htrans, dmem_htrans;
    logic dmem_hwrite, uart_hreadyout, uart_hresp;
    logic [31:0] dmem_hwdata, uart_hrdata;
    logic soc_rst_n, heartbeat_led, imem_hready, imem_hresp;
    logic dmem_hready, dmem_hresp, uart_hsel, uart_hwrite;
    logic [31:0] imem_hrdata, dmem_hrdata, uart_haddr, uart_hwdata;

    int error_count = 0;
    int check_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int cycle_count = 0;
    // responder controls, set by the tests
    int uart_wait_cfg = 0;
    logic [31:0] uart_word = '0;
    logic uart_req = 1'b0;
    int wait_left;

    soc_fabric_top i_dut (.*);

    initial begin
        cpu_clk = 1'b0;
        forever #20 cpu_clk = ~cpu_clk;
    end

    // ====================
    // uart responder
    // ====================
    // address phase seen mid-cycle, accepted at the next edge
    always @(negedge cpu_clk) begin
        uart_req = uart_hsel && dmem_hready
                 && (dmem_htrans == htrans_nonseq || dmem_htrans == htrans_seq);
    end

    initial begin
        uart_hreadyout = 1'b1;
        uart_hrdata = '0;
        uart_hresp = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge cpu_clk);
            #2;
            if (uart_req) begin
                wait_left = uart_wait_cfg;
            end else if (wait_left > 0) begin
                wait_left--;
            end
            uart_hreadyout = (wait_left == 0);
            // data only on the ready cycle, so early forwarding shows up
            uart_hrdata = (wait_left == 0) ? uart_word : 32'h0;
        end
    end

    // ====================
    // helpers
    // ====================
    task automatic next_cycle();
        @(posedge cpu_clk);
        #2;
    endtask

    function automatic logic [31:0] expected_rom_word(input int idx);
        return 32'hB0070000 + idx;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        test_count++;
        if (error_count != start_errors) begin
            failed_tests++;
        end
        $display("%-16s %s", name, (error_count == start_errors) ? "ok" : "FAIL");
    endtask

    // one data-port transfer, returns once its data phase completes
    task automatic dmem_xfer(input logic [31:0] addr, input logic wr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic resp, output int waits, output logic sel_seen);
        dmem_haddr = addr;
        dmem_htrans = htrans_nonseq;
        dmem_hwrite = wr;
        #5;
        sel_seen = uart_hsel;
        // uart bus carries the address phase unchanged
        check_value("uart_haddr", uart_haddr, addr);
        check_bit("uart_hwrite", uart_hwrite, wr);
        next_cycle();
        dmem_htrans = htrans_idle;
        dmem_hwdata = wdata;
        waits = 0;
        #5;
        while (!dmem_hready) begin
            next_cycle();
            #5;
            waits++;
        end
        check_value("uart_hwdata", uart_hwdata, wdata);
        rdata = dmem_hrdata;
        resp = dmem_hresp;
        next_cycle();
    endtask

    // ====================
    // tests
    // ====================
    task automatic test_reset_release();
        int n;
        int start_errors;
        start_errors = error_count;
        repeat (4) next_cycle();
        check_bit("soc_rst_n", soc_rst_n, 1'b0);
        check_bit("heartbeat_led", heartbeat_led, 1'b0);
        ext_rst_n = 1'b1;
        n = 0;
        while (!soc_rst_n) begin
            next_cycle();
            n++;
        end
        assert (n >= 16 && n <= 20) else begin
            $display("soc_rst_n released after %0d cycles, not within 16 to 20", n);
            error_count++;
        end
        // press again, then glitch low inside the window
        ext_rst_n = 1'b0;
        repeat (4) next_cycle();
        check_bit("soc_rst_n", soc_rst_n, 1'b0);
        ext_rst_n = 1'b1;
        repeat (8) next_cycle();
        check_bit("soc_rst_n", soc_rst_n, 1'b0);
        ext_rst_n = 1'b0;
        next_cycle();
        ext_rst_n = 1'b1;
        n = 0;
        while (!soc_rst_n) begin
            next_cycle();
            n++;
        end
        assert (n >= 16) else begin
            $display("glitch did not restart the window, release after %0d cycles", n);
            error_count++;
        end
        finish_test("reset release", start_errors);
    endtask

    task automatic test_heartbeat();
        int gap;
        int start_errors;
        logic prev;
        start_errors = error_count;
        prev = heartbeat_led;
        while (heartbeat_led == prev) next_cycle();
        repeat (3) begin
            prev = heartbeat_led;
            gap = 0;
            while (heartbeat_led == prev) begin
                next_cycle();
                gap++;
            end
            check_value("heartbeat gap", gap, 32'd25);
        end
        finish_test("heartbeat", start_errors);
    endtask

    task automatic test_instr_fetch();
        int idx;
        int start_errors;
        start_errors = error_count;
        idx = 0;
        // back-to-back nonseq fetches
        repeat (8) begin
            idx = $urandom_range(15, 0);
            imem_haddr = rom_base + 4 * idx;
            imem_htrans = htrans_nonseq;
            next_cycle();
            check_value("imem_hrdata", imem_hrdata, expected_rom_word(idx));
            check_bit("imem_hready", imem_hready, 1'b1);
            check_bit("imem_hresp", imem_hresp, 1'b0);
        end
        // idle holds the last word
        imem_htrans = htrans_idle;
        imem_haddr = rom_base + 4 * ((idx + 1) % 16);
        next_cycle();
        check_value("imem_hrdata", imem_hrdata, expected_rom_word(idx));
        finish_test("instr fetch", start_errors);
    endtask

    task automatic test_rom_data();
        int idx;
        int waits;
        int start_errors;
        logic [31:0] rdata;
        logic resp, sel;
        start_errors = error_count;
        repeat (4) begin
            idx = $urandom_range(15, 0);
            dmem_xfer(rom_base + 4 * idx, 1'b0, '0, rdata, resp, waits, sel);
            check_value("dmem_hrdata", rdata, expected_rom_word(idx));
            check_value("rom wait states", waits, 32'd0);
            check_bit("dmem_hresp", resp, 1'b0);
        end
        // unmapped answers zero and OKAY
        dmem_xfer(32'h2000_0010, 1'b0, '0, rdata, resp, waits, sel);
        check_value("dmem_hrdata", rdata, 32'h0);
        check_bit("dmem_hresp", resp, 1'b0);
        // write is dropped
        idx = $urandom_range(15, 0);
        dmem_xfer(rom_base + 4 * idx, 1'b1, $urandom(), rdata, resp, waits, sel);
        dmem_xfer(rom_base + 4 * idx, 1'b0, '0, rdata, resp, waits, sel);
        check_value("dmem_hrdata", rdata, expected_rom_word(idx));
        finish_test("rom data", start_errors);
    endtask

    task automatic test_uart_window();
        int waits;
        int start_errors;
        logic [31:0] rdata;
        logic resp, sel;
        start_errors = error_count;
        for (int k = 0; k <= 3; k++) begin
            uart_wait_cfg = k;
            uart_word = $urandom();
            dmem_xfer(uart_base + 4 * $urandom_range(7, 0), 1'b0, '0, rdata, resp, waits, sel);
            check_bit("uart_hsel", sel, 1'b1);
            check_value("uart wait states", waits, k);
            check_value("dmem_hrdata", rdata, uart_word);
            check_bit("dmem_hresp", resp, 1'b0);
        end
        uart_wait_cfg = 0;
        finish_test("uart window", start_errors);
    endtask

    // ====================
    // run
    // ====================
    initial begin
        while (cycle_count < timeout_cycles) begin
            @(posedge cpu_clk);
            cycle_count++;
        end
        $display("timeout, run stopped after %0d cycles", cycle_count);
        $display("sim failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hda4f));
        hard_rst_n = 1'b0;
        ext_rst_n = 1'b0;
        imem_haddr = '0;
        imem_htrans = htrans_idle;
        dmem_haddr = '0;
        dmem_htrans = htrans_idle;
        dmem_hwrite = 1'b0;
        dmem_hwdata = '0;
        repeat (5) @(posedge cpu_clk);
        #2;
        hard_rst_n = 1'b1;
        test_reset_release();
        test_heartbeat();
        test_instr_fetch();
        test_rom_data();
        test_uart_window();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* soc_asserts.sv */
/*
 * bus and reset properties, bound into soc_fabric_top.
 * sampled on cpu_clk; the UART check is ignored while the SoC is in reset.
 */
`timescale 1ns/10ps
`default_nettype none

module soc_asserts (
    input  wire logic       cpu_clk,
    input  wire logic       hard_rst_n,
    input  wire logic       ext_rst_n,
    input  wire logic       soc_rst_n,
    input  wire logic       uart_hsel,
    input  wire logic       uart_hreadyout,
    input  wire logic [1:0] dmem_htrans,
    input  wire logic       dmem_hready
);
    import soc_pkg::*;

    // button press reaches the SoC reset through the synchronizer
    btn_press_rst: assert property (@(posedge cpu_clk) disable iff (!hard_rst_n)
        $fell(ext_rst_n) |-> ##3 !soc_rst_n) else $error("soc_rst_n late after button press");

    // accepted uart address phase, its data phase follows the uart ready
    uart_ready_routed: assert property (@(posedge cpu_clk) disable iff (!soc_rst_n)
        uart_hsel && dmem_hready
        && (dmem_htrans == htrans_nonseq || dmem_htrans == htrans_seq)
        |=> (dmem_hready == uart_hreadyout)) else $error("uart data phase not routed");

    // hard reset reaches the SoC reset
    hard_rst_wins: assert property (@(posedge cpu_clk)
        !hard_rst_n |-> !soc_rst_n) else $error("soc_rst_n high under hard reset");

    // first cycle out of reset, nothing selected
    ready_after_rst: assert property (@(posedge cpu_clk)
        $rose(soc_rst_n) |-> dmem_hready) else $error("dmem_hready low after reset");

endmodule

bind soc_fabric_top soc_asserts i_soc_asserts (
    .cpu_clk        (cpu_clk),
    .hard_rst_n     (hard_rst_n),
    .ext_rst_n      (ext_rst_n),
    .soc_rst_n      (soc_rst_n),
    .uart_hsel      (uart_hsel),
    .uart_hreadyout (uart_hreadyout),
    .dmem_htrans    (dmem_htrans),
    .dmem_hready    (dmem_hready)
);

`default_nettype wire

/* soc_fabric_top.sv */
/*
 * SoC glue around an external RISC-V core and an external UART.
 * instruction port is ROM only, always ready and OKAY.
 * the UART sees the data-port address and write signals unchanged.
 */
`timescale 1ns/10ps
`default_nettype none

module soc_fabric_top (
    input  wire logic                          cpu_clk,
    input  wire logic                          hard_rst_n,
    input  wire logic                          ext_rst_n,
    // instruction master
    input  wire soc_pkg::bus_addr_t            imem_haddr,
    input  wire logic [1:0]                    imem_htrans,
    // data master
    input  wire soc_pkg::bus_addr_t            dmem_haddr,
    input  wire logic [1:0]                    dmem_htrans,
    input  wire logic                          dmem_hwrite,
    input  wire logic [soc_pkg::ahb_width-1:0] dmem_hwdata,
    // uart slave response
    input  wire logic [soc_pkg::ahb_width-1:0] uart_hrdata,
    input  wire logic                          uart_hreadyout,
    input  wire logic                          uart_hresp,
    output logic                               soc_rst_n,
    output logic                               heartbeat_led,
    output logic [soc_pkg::ahb_width-1:0]      imem_hrdata,
    output logic                               imem_hready,
    output logic                               imem_hresp,
    output logic [soc_pkg::ahb_width-1:0]      dmem_hrdata,
    output logic                               dmem_hready,
    output logic                               dmem_hresp,
    // uart slave request
    output logic                               uart_hsel,
    output logic [soc_pkg::ahb_width-1:0]      uart_haddr,
    output logic                               uart_hwrite,
    output logic [soc_pkg::ahb_width-1:0]      uart_hwdata
);
    import soc_pkg::*;

    logic                 rom_hsel;
    logic [ahb_width-1:0] rom_hrdata;

    // ====================
    // reset and heartbeat
    // ====================
    rst_conditioner i_rst_conditioner (
        .cpu_clk    (cpu_clk),
        .hard_rst_n (hard_rst_n),
        .ext_rst_n  (ext_rst_n),
        .soc_rst_n  (soc_rst_n)
    );

    heartbeat_blinker i_heartbeat_blinker (
        .cpu_clk       (cpu_clk),
        .soc_rst_n     (soc_rst_n),
        .heartbeat_led (heartbeat_led)
    );

    // ====================
    // memory and decode
    // ====================
    boot_rom i_boot_rom (
        .cpu_clk     (cpu_clk),
        .soc_rst_n   (soc_rst_n),
        .imem_haddr  (imem_haddr),
        .imem_htrans (imem_htrans),
        .dmem_haddr  (dmem_haddr),
        .dmem_htrans (dmem_htrans),
        .dmem_hready (dmem_hready),
        .rom_hsel    (rom_hsel),
        .imem_hrdata (imem_hrdata),
        .rom_hrdata  (rom_hrdata)
    );

    dmem_slave_mux i_dmem_slave_mux (
        .cpu_clk        (cpu_clk),
        .soc_rst_n      (soc_rst_n),
        .dmem_haddr     (dmem_haddr),
        .dmem_htrans    (dmem_htrans),
        .rom_hrdata     (rom_hrdata),
        .uart_hrdata    (uart_hrdata),
        .uart_hreadyout (uart_hreadyout),
        .uart_hresp     (uart_hresp),
        .rom_hsel       (rom_hsel),
        .uart_hsel      (uart_hsel),
        .dmem_hrdata    (dmem_hrdata),
        .dmem_hready    (dmem_hready),
        .dmem_hresp     (dmem_hresp)
    );

    // fixed one-cycle ROM, never stalls or errors
    assign imem_hready = 1'b1;
    assign imem_hresp  = 1'b0;

    // uart shares the data bus
    assign uart_haddr  = dmem_haddr;
    assign uart_hwrite = dmem_hwrite;
    assign uart_hwdata = dmem_hwdata;

endmodule

`default_nettype wire

/* dmem_slave_mux.sv */
/*
 * data-side decoder and response mux for the ROM and the external UART.
 * the select is captured on every accepted address phase; an unmapped
 * transfer answers zero data, ready and OKAY. the ROM is always ready.
 */
`timescale 1ns/10ps
`default_nettype none

module dmem_slave_mux (
    input  wire logic                          cpu_clk,
    input  wire logic                          soc_rst_n,
    input  wire soc_pkg::bus_addr_t            dmem_haddr,
    input  wire logic [1:0]                    dmem_htrans,
    input  wire logic [soc_pkg::ahb_width-1:0] rom_hrdata,
    input  wire logic [soc_pkg::ahb_width-1:0] uart_hrdata,
    input  wire logic                          uart_hreadyout,
    input  wire logic                          uart_hresp,
    output logic                               rom_hsel,
    output logic                               uart_hsel,
    output logic [soc_pkg::ahb_width-1:0]      dmem_hrdata,
    output logic                               dmem_hready,
    output logic                               dmem_hresp
);
    import soc_pkg::*;

    logic       trans_active;
    logic       addr_accept;
    logic [1:0] sel_q;          // {rom, uart} of the transfer in data phase

    // ====================
    // address phase
    // ====================
    // same word, two views of its upper bits
    assign rom_hsel  = (dmem_haddr.rom.page == rom_page);
    assign uart_hsel = (dmem_haddr.uart.page == uart_page);

    assign trans_active = (dmem_htrans != htrans_idle) && (dmem_htrans != htrans_busy);
    assign addr_accept  = trans_active && dmem_hready;

    always_ff @(posedge cpu_clk or negedge soc_rst_n) begin
        if (!soc_rst_n) begin
            sel_q <= 2'b00;
        end else if (addr_accept) begin
            // unmapped address clears the select
            sel_q <= {rom_hsel, uart_hsel};
        end
    end

    // ====================
    // data phase
    // ====================
    always_comb begin
        unique case (sel_q)
            2'b10: begin
                dmem_hrdata = rom_hrdata;
                dmem_hready = 1'b1;
                dmem_hresp  = 1'b0;
            end
            2'b01: begin
                // uart may stretch the data phase
                dmem_hrdata = uart_hrdata;
                dmem_hready = uart_hreadyout;
                dmem_hresp  = uart_hresp;
            end
            default: begin
                dmem_hrdata = '0;
                dmem_hready = 1'b1;
                dmem_hresp  = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* boot_rom.sv */
/*
 * two-port boot ROM, one cycle read latency on both ports, image from rom_image.hex.
 * writes are never stored. the data port relies on rom_hsel from the slave mux.
 * read data holds until the next read on the same port.
 */
`timescale 1ns/10ps
`default_nettype none

module boot_rom (
    input  wire logic                          cpu_clk,
    input  wire logic                          soc_rst_n,
    input  wire soc_pkg::bus_addr_t            imem_haddr,
    input  wire logic [1:0]                    imem_htrans,
    input  wire soc_pkg::bus_addr_t            dmem_haddr,
    input  wire logic [1:0]                    dmem_htrans,
    input  wire logic                          dmem_hready,
    input  wire logic                          rom_hsel,
    output logic [soc_pkg::ahb_width-1:0]      imem_hrdata,
    output logic [soc_pkg::ahb_width-1:0]      rom_hrdata
);
    import soc_pkg::*;

    logic [ahb_width-1:0] rom_mem [rom_words];
    logic                 imem_rd;
    logic                 dmem_rd;

    initial begin
        $readmemh(rom_image_file, rom_mem);
    end

    // ====================
    // read strobes
    // ====================
    // instruction side has no mux in front, so it decodes its own page
    assign imem_rd = soc_rst_n
                   && (imem_htrans inside {htrans_nonseq, htrans_seq})
                   && (imem_haddr.rom.page == rom_page);

    // data side only on an accepted address phase
    assign dmem_rd = soc_rst_n
                   && (dmem_htrans inside {htrans_nonseq, htrans_seq})
                   && rom_hsel
                   && dmem_hready;

    // data phase registers, word index straight from the union view
    always_ff @(posedge cpu_clk) begin
        if (imem_rd) begin
            imem_hrdata <= rom_mem[imem_haddr.rom.index];
        end
        if (dmem_rd) begin
            rom_hrdata <= rom_mem[dmem_haddr.rom.index];
        end
    end

endmodule

`default_nettype wire

/* heartbeat_blinker.sv */
/*
 * heartbeat LED, one toggle every heartbeat_reload+1 cycles.
 * the LED lags the internal tick by one cycle and is low out of reset.
 */
`timescale 1ns/10ps
`default_nettype none

module heartbeat_blinker (
    input  wire logic cpu_clk,
    input  wire logic soc_rst_n,
    output logic      heartbeat_led
);
    import soc_pkg::*;

    logic [$bits(heartbeat_reload)-1:0] beat_cnt;
    logic                               tick;

    // reloading down-counter, tick on the reload edge
    always_ff @(posedge cpu_clk or negedge soc_rst_n) begin
        if (!soc_rst_n) begin
            beat_cnt <= '0;
            tick     <= 1'b0;
        end else if (beat_cnt == '0) begin
            beat_cnt <= heartbeat_reload;
            tick     <= 1'b1;
        end else begin
            beat_cnt <= beat_cnt - 1'b1;
            tick     <= 1'b0;
        end
    end

    // toggle flop
    always_ff @(posedge cpu_clk or negedge soc_rst_n) begin
        if (!soc_rst_n) begin
            heartbeat_led <= 1'b0;
        end else if (tick) begin
            heartbeat_led <= ~heartbeat_led;
        end
    end

endmodule

`default_nettype wire

/* rst_conditioner.sv */
/*
 * button reset conditioning. hard_rst_n clears everything at once.
 * the button must stay high for 16 synchronized cycles before soc_rst_n rises.
 */
`timescale 1ns/10ps
`default_nettype none

module rst_conditioner (
    input  wire logic cpu_clk,
    input  wire logic hard_rst_n,
    input  wire logic ext_rst_n,
    output logic      soc_rst_n
);
    import soc_pkg::*;

    logic [1:0]               btn_sync;
    logic [rst_stretch_w-1:0] stretch_cnt;
    logic                     rst_q;

    // two-flop synchronizer for the button
    always_ff @(posedge cpu_clk or negedge hard_rst_n) begin
        if (!hard_rst_n) begin
            btn_sync <= '0;
        end else begin
            btn_sync <= {btn_sync[0], ext_rst_n};
        end
    end

    // ====================
    // release window
    // ====================
    always_ff @(posedge cpu_clk or negedge hard_rst_n) begin
        if (!hard_rst_n) begin
            rst_q       <= 1'b0;
            stretch_cnt <= '0;
        end else if (rst_q) begin
            // running, drop straight back into reset on a low sample
            rst_q       <= btn_sync[1];
            stretch_cnt <= '0;
        end else if (!btn_sync[1]) begin
            // low inside the window, start over
            stretch_cnt <= '0;
        end else if (stretch_cnt == '1) begin
            // sixteenth high sample in a row
            rst_q <= 1'b1;
        end else begin
            stretch_cnt <= stretch_cnt + 1'b1;
        end
    end

    assign soc_rst_n = rst_q;

endmodule

`default_nettype wire

/* soc_pkg.sv */
/*
 * memory map, bus constants and the shared address type of the board SoC.
 * the ROM serves whole 32-bit words only; byte lanes are not decoded.
 * heartbeat_reload is sized for simulation and would be half the clock on a board.
 */
`default_nettype none

package soc_pkg;

    // ====================
    // bus
    // ====================
    localparam int ahb_width = 32;

    // AHB-Lite transfer codes
    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_busy   = 2'b01;
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;

    // ====================
    // memory map
    // ====================
    localparam int rom_words   = 32768;
    localparam int rom_index_w = 15;

    // rom window at 32'hFFEE0000, bits 31:17
    localparam logic [14:0] rom_page  = 15'h7FF7;
    // uart window at 32'hFFDF0000, bits 31:16
    localparam logic [15:0] uart_page = 16'hFFDF;

    localparam string rom_image_file = "rom_image.hex";

    // ====================
    // reset and heartbeat
    // ====================
    localparam int          rst_stretch_w    = 4;
    localparam logic [4:0]  heartbeat_reload = 5'd24;

    // one address word, read as a rom word index or as a uart register offset
    typedef union packed {
        struct packed {
            logic [$bits(rom_page)-1:0] page;
            logic [rom_index_w-1:0]     index;
            logic [1:0]                 byte_off;
        } rom;
        struct packed {
            logic [$bits(uart_page)-1:0] page;
            logic [15:0]                 reg_off;
        } uart;
    } bus_addr_t;

endpackage

`default_nettype wire
